/* hw/ref_mem_pkg.sv */
package ref_mem_pkg;

	// reference memory geometry
	localparam int num_banks      = 32;
	localparam int bank_group     = 4;
	localparam int num_groups     = num_banks / bank_group;
	localparam int lines_per_bank = 96;

	// search-area-1 read walk
	localparam int search_cols   = 7;
	localparam int rows_per_half = 24;

	// rows held twice for reference reuse
	localparam int stall_first = 7;
	localparam int stall_last  = 19;

	// bank offset per column
	localparam int col_step = 8;

	// line offset of the second half, also applied once per bank wrap
	localparam int half_offset = 24;

	typedef logic [$clog2(lines_per_bank)-1:0] line_addr_t;
	typedef logic [num_banks-1:0] bank_mask_t;

	// bank 0 sits in the low bits
	typedef logic [num_banks*$bits(line_addr_t)-1:0] bank_addr_vec_t;

	typedef logic [$clog2(num_banks)-1:0] shift_t;
	typedef logic [$clog2(search_cols)-1:0] col_idx_t;
	typedef logic [$clog2(num_groups)-1:0] group_idx_t;

	typedef enum logic [1:0] {
		idle,
		preload,
		search,
		done
	} phase_t;

endpackage

/* hw/ref_mem_phase_ctrl.sv */
`timescale 1ns/1ps

module ref_mem_phase_ctrl (
	input  logic clk,
	input  logic rst_n,
	input  logic start_req,
	input  logic preload_last,
	input  logic search_last,
	output logic start_ack,
	output logic preload_go,
	output logic search_go
);
	import ref_mem_pkg::*;

	phase_t phase;
	phase_t phase_nxt;
	logic   ack_nxt;

	always_comb begin
		phase_nxt = phase;
		ack_nxt   = start_ack;
		case (phase)
			idle: begin
				// a fresh request only counts with the ack already low
				if (start_req && !start_ack) begin
					phase_nxt = preload;
				end
			end
			preload: begin
				if (preload_last) begin
					phase_nxt = search;
				end
			end
			search: begin
				if (search_last) begin
					phase_nxt = done;
				end
			end
			done: begin
				// first done cycle lets the map's last read leave
				if (!start_ack) begin
					ack_nxt = 1'b1;
				end else if (!start_req) begin
					ack_nxt   = 1'b0;
					phase_nxt = idle;
				end
			end
			default: begin
				phase_nxt = idle;
				ack_nxt   = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase      <= idle;
			start_ack  <= 1'b0;
			preload_go <= 1'b0;
			search_go  <= 1'b0;
		end else begin
			phase     <= phase_nxt;
			start_ack <= ack_nxt;
			// one-cycle kicks on phase entry
			preload_go <= (phase == idle) && (phase_nxt == preload);
			search_go  <= (phase == preload) && (phase_nxt == search);
		end
	end

endmodule

/* hw/preload_addr_gen.sv */
`timescale 1ns/1ps

module preload_addr_gen (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    preload_go,
	output ref_mem_pkg::bank_mask_t bank_sel,
	output ref_mem_pkg::line_addr_t wr_addr,
	output logic                    preload_last
);
	import ref_mem_pkg::*;

	group_idx_t group;
	logic       active;
	logic       line_end;

	// mask is nonzero only while writing
	assign active   = (bank_sel != '0);
	assign line_end = (wr_addr == line_addr_t'(lines_per_bank - 1));

	// last line of the top group
	assign preload_last = active && line_end &&
		(group == group_idx_t'(num_groups - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bank_sel <= '0;
			wr_addr  <= '0;
			group    <= '0;
		end else if (preload_go) begin
			bank_sel <= bank_mask_t'({bank_group{1'b1}});
			wr_addr  <= '0;
			group    <= '0;
		end else if (active) begin
			if (line_end) begin
				wr_addr <= '0;
				group   <= group + 1'b1;
				// mask walks up one group, falls off after the last
				bank_sel <= bank_sel << bank_group;
			end else begin
				wr_addr <= wr_addr + 1'b1;
			end
		end
	end

endmodule

/* hw/search_row_seq.sv */
`timescale 1ns/1ps

module search_row_seq (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    search_go,
	output ref_mem_pkg::line_addr_t row,
	output logic                    half,
	output ref_mem_pkg::col_idx_t   col,
	output logic                    step_valid,
	output logic                    search_last
);
	import ref_mem_pkg::*;

	logic rep;
	logic stall_row;
	logic hold;
	logic row_end;
	logic col_end;

	assign stall_row = (row >= line_addr_t'(stall_first)) &&
		(row <= line_addr_t'(stall_last));

	// first visit of a stall row repeats it
	assign hold = stall_row && !rep;

	assign row_end = (row == line_addr_t'(rows_per_half - 1));
	assign col_end = (col == col_idx_t'(search_cols - 1));

	// row 23 never stalls, so this is the single final step
	assign search_last = step_valid && row_end && half && col_end;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			step_valid <= 1'b0;
			row        <= '0;
			half       <= 1'b0;
			col        <= '0;
			rep        <= 1'b0;
		end else if (search_go) begin
			step_valid <= 1'b1;
			row        <= '0;
			half       <= 1'b0;
			col        <= '0;
			rep        <= 1'b0;
		end else if (step_valid) begin
			if (hold) begin
				rep <= 1'b1;
			end else begin
				rep <= 1'b0;
				if (!row_end) begin
					row <= row + 1'b1;
				end else begin
					row <= '0;
					if (!half) begin
						half <= 1'b1;
					end else begin
						half <= 1'b0;
						if (col_end) begin
							step_valid <= 1'b0;
							col        <= '0;
						end else begin
							col <= col + 1'b1;
						end
					end
				end
			end
		end
	end

endmodule

/* hw/bank_addr_map.sv */
`timescale 1ns/1ps

module bank_addr_map (
	input  logic                        clk,
	input  logic                        rst_n,
	input  ref_mem_pkg::line_addr_t     row,
	input  logic                        half,
	input  ref_mem_pkg::col_idx_t       col,
	input  logic                        step_valid,
	output logic                        rd_en,
	output ref_mem_pkg::bank_addr_vec_t rd_addr,
	output ref_mem_pkg::shift_t         shift_value
);
	import ref_mem_pkg::*;

	localparam int lw = $bits(line_addr_t);

	logic [6:0]     col_offset;
	line_addr_t     base_line;
	bank_addr_vec_t addr_nxt;

	assign col_offset = 7'(col) * 7'(col_step);
	assign base_line  = row + (half ? line_addr_t'(half_offset) : '0);

	for (genvar b = 0; b < num_banks; b++) begin : g_bank
		logic [6:0] pos;
		logic [1:0] wraps;

		// bank position across the column window
		assign pos   = 7'(b) + col_offset;
		assign wraps = 2'(pos / num_banks);
		assign addr_nxt[b*lw +: lw] = base_line + line_addr_t'(wraps * half_offset);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_en       <= 1'b0;
			shift_value <= '0;
		end else begin
			rd_en <= step_valid;
			if (step_valid) begin
				// truncation gives the modulo over the PE array
				shift_value <= shift_t'(col * col_step);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (step_valid) begin
			rd_addr <= addr_nxt;
		end
	end

endmodule

/* hw/ref_mem_ctrl.sv */
`timescale 1ns/1ps

module ref_mem_ctrl (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        start_req,
	output logic                        start_ack,
	output ref_mem_pkg::bank_mask_t     bank_sel,
	output ref_mem_pkg::line_addr_t     wr_addr,
	output logic                        rd_en,
	output ref_mem_pkg::bank_addr_vec_t rd_addr,
	output ref_mem_pkg::shift_t         shift_value
);
	import ref_mem_pkg::*;

	logic       preload_go;
	logic       search_go;
	logic       preload_last;
	logic       search_last;

	// sequencer to map
	line_addr_t row;
	logic       half;
	col_idx_t   col;
	logic       step_valid;

	ref_mem_phase_ctrl phase_ctrl_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.start_req    (start_req),
		.preload_last (preload_last),
		.search_last  (search_last),
		.start_ack    (start_ack),
		.preload_go   (preload_go),
		.search_go    (search_go)
	);

	preload_addr_gen preload_addr_gen_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.preload_go   (preload_go),
		.bank_sel     (bank_sel),
		.wr_addr      (wr_addr),
		.preload_last (preload_last)
	);

	search_row_seq search_row_seq_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.search_go   (search_go),
		.row         (row),
		.half        (half),
		.col         (col),
		.step_valid  (step_valid),
		.search_last (search_last)
	);

	// one registered stage to the memory
	bank_addr_map bank_addr_map_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.row         (row),
		.half        (half),
		.col         (col),
		.step_valid  (step_valid),
		.rd_en       (rd_en),
		.rd_addr     (rd_addr),
		.shift_value (shift_value)
	);

endmodule

/* test/ref_mem_clk_gen.sv */
`timescale 1ns/1ps

module ref_mem_clk_gen (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// reset held for 5 cycles, released on a falling edge
	initial begin
		rst_n = 1'b0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n <= 1'b1;
	end

endmodule

/* test/ref_mem_tb.sv */
`timescale 1ns/1ps

module ref_mem_tb;
	import ref_mem_pkg::*;

	// reset plus 3 passes of 1400 cycles needs 4205 cycles
	localparam int timeout_cycles = 4300;

	logic           clk;
	logic           rst_n;
	logic           start_req;
	logic           start_ack;
	bank_mask_t     bank_sel;
	line_addr_t     wr_addr;
	logic           rd_en;
	bank_addr_vec_t rd_addr;
	shift_t         shift_value;

	logic [31:0] lfsr = 32'ha2937e71;
	int          error_count = 0;
	int          cycle_count = 0;
	int          exp_row [518];
	int          exp_half [518];
	int          exp_col [518];

	ref_mem_clk_gen clk_gen_inst (
		.clk   (clk),
		.rst_n (rst_n)
	);

	ref_mem_ctrl ref_mem_ctrl_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.start_req   (start_req),
		.start_ack   (start_ack),
		.bank_sel    (bank_sel),
		.wr_addr     (wr_addr),
		.rd_en       (rd_en),
		.rd_addr     (rd_addr),
		.shift_value (shift_value)
	);

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic int random_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = (v << 1) | lfsr[0];
		end
		return v;
	endfunction

	task automatic report_error(input string msg);
		$display("ERROR %0t: %s", $time, msg);
		error_count++;
	endtask

	// expected read steps by column, half and row with rows 7..19 doubled
	task automatic build_read_model();
		int k;
		k = 0;
		for (int c = 0; c < 7; c++) begin
			for (int h = 0; h < 2; h++) begin
				for (int r = 0; r < 24; r++) begin
					for (int n = 0; n < ((r >= 7 && r <= 19) ? 2 : 1); n++) begin
						exp_row[k]  = r;
						exp_half[k] = h;
						exp_col[k]  = c;
						k++;
					end
				end
			end
		end
	endtask

	task automatic check_quiet(input string where);
		assert (bank_sel == '0 && rd_en == 1'b0)
		else report_error($sformatf("memory access while %s", where));
	endtask

	task automatic check_write(input int k);
		bank_mask_t exp_sel;
		exp_sel = bank_mask_t'(32'hf) << (4 * (k / 96));
		assert (bank_sel === exp_sel && wr_addr === line_addr_t'(k % 96) &&
			rd_en === 1'b0)
		else report_error($sformatf(
			"write %0d: bank_sel %h wr_addr %0d rd_en %b, expected %h %0d 0",
			k, bank_sel, wr_addr, rd_en, exp_sel, k % 96));
	endtask

	task automatic check_read(input int k);
		int line;
		int bad;
		int bad_exp;
		bad = -1;
		bad_exp = 0;
		for (int b = 0; b < 32; b++) begin
			line = exp_row[k] + 24 * exp_half[k] + 24 * ((b + 8 * exp_col[k]) / 32);
			if (rd_addr[b*7 +: 7] !== 7'(line) && bad < 0) begin
				bad = b;
				bad_exp = line;
			end
		end
		assert (bad < 0)
		else report_error($sformatf("read %0d: bank %0d line %0d, expected %0d",
			k, bad, rd_addr[bad*7 +: 7], bad_exp));
		assert (shift_value === shift_t'((8 * exp_col[k]) % 32))
		else report_error($sformatf("read %0d: shift_value %0d, expected %0d",
			k, shift_value, (8 * exp_col[k]) % 32));
	endtask

	task automatic run_pass(input int p, inout int passed);
		int             gap;
		int             hold;
		int             wi;
		int             ri;
		int             cyc;
		int             last_wr;
		int             repeats;
		int             first_err;
		logic           acked;
		logic           prev_rd;
		bank_addr_vec_t prev_addr;
		shift_t         prev_shift;
		gap = random_bits(6);
		hold = random_bits(4);
		first_err = error_count;
		wi = 0;
		ri = 0;
		cyc = 0;
		last_wr = 0;
		repeats = 0;
		acked = 1'b0;
		prev_rd = 1'b0;
		repeat (gap) begin
			@(negedge clk);
			check_quiet("idle with start_req low");
		end
		start_req = 1'b1;
		while (!acked) begin
			@(negedge clk);
			cyc++;
			if (start_ack) begin
				acked = 1'b1;
				assert (wi == 768 && ri == 518)
				else report_error($sformatf("start_ack rose after %0d writes and %0d reads",
					wi, ri));
				check_quiet("start_ack is high");
			end else begin
				if (bank_sel != '0) begin
					assert (wi < 768 && (wi == 0 || last_wr == cyc - 1))
					else report_error($sformatf("write %0d not part of 768 consecutive lines",
						wi));
					if (wi < 768) begin
						check_write(wi);
					end
					last_wr = cyc;
					wi++;
				end
				if (rd_en) begin
					// first read comes at most 4 idle cycles after the last write
					assert (wi == 768 && ri < 518 &&
						(ri == 0 ? cyc - last_wr <= 5 : prev_rd))
					else report_error($sformatf("read %0d out of order with the writes", ri));
					if (ri < 518) begin
						check_read(ri);
					end
					if (prev_rd && rd_addr === prev_addr && shift_value === prev_shift) begin
						repeats++;
					end
					ri++;
				end
				prev_rd = rd_en;
				prev_addr = rd_addr;
				prev_shift = shift_value;
			end
		end
		// 13 stalled rows in each of 14 halves
		assert (repeats == 182)
		else report_error($sformatf("%0d repeated reads, expected 182", repeats));
		repeat (hold) begin
			@(negedge clk);
			assert (start_ack) else report_error("start_ack dropped while start_req high");
			check_quiet("start_ack is high");
		end
		start_req = 1'b0;
		@(negedge clk);
		assert (!start_ack) else report_error("start_ack did not fall one clock after start_req");
		check_quiet("idle with start_req low");
		if (error_count == first_err) begin
			passed++;
		end
		$display("pass %0d: %0d writes, %0d reads, gap %0d, hold %0d: %s",
			p, wi, ri, gap, hold, (error_count == first_err) ? "ok" : "failed");
	endtask

	initial begin
		int reset_errors;
		int passed;
		start_req = 1'b0;
		passed = 0;
		build_read_model();
		reset_errors = error_count;
		while (rst_n !== 1'b1) begin
			@(negedge clk);
			assert (bank_sel === '0 && rd_en === 1'b0 && start_ack === 1'b0 &&
				shift_value === '0)
			else report_error("outputs not idle during or right after reset");
		end
		if (error_count == reset_errors) begin
			passed++;
		end
		$display("reset: %s", (error_count == reset_errors) ? "ok" : "failed");
		for (int p = 1; p <= 3; p++) begin
			run_pass(p, passed);
		end
		$display("%0d of 4 tests ok, %0d errors", passed, error_count);
		if (error_count == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= timeout_cycles) begin
			$display("timeout: the run did not finish within %0d cycles", timeout_cycles);
			$display("tests failed");
			$finish;
		end
	end

endmodule

/* files.f */
hw/ref_mem_pkg.sv
hw/ref_mem_phase_ctrl.sv
hw/preload_addr_gen.sv
hw/search_row_seq.sv
hw/bank_addr_map.sv
hw/ref_mem_ctrl.sv
test/ref_mem_clk_gen.sv
test/ref_mem_tb.sv
